//--- hdl/mpu_pkg.sv
// Machine word definitions
`default_nettype none

package mpu_pkg;

	////////////////////
	// Field widths
	////////////////////

	localparam int WIDTH_THREAD_ID	= 6;		// 64 threads
	localparam int WIDTH_ISSUE_NO	= 8;		// Running issue count
	localparam int WIDTH_IADDR		= 10;		// 1024 instruction words
	localparam int WIDTH_ILEN		= 11;		// Lengths 1 to 1024
	localparam int WIDTH_INSTR		= 32;

	// Table and memory depths
	localparam int NUM_THREADS		= 1 << WIDTH_THREAD_ID;
	localparam int IMEM_DEPTH		= 1 << WIDTH_IADDR;

	////////////////////
	// Vector types
	////////////////////

	typedef logic [WIDTH_THREAD_ID-1:0]	id_t;
	typedef logic [WIDTH_ISSUE_NO-1:0]	issue_no_t;
	typedef logic [WIDTH_IADDR-1:0]		iaddr_t;
	typedef logic [WIDTH_ILEN-1:0]		ilen_t;		// One bit wider than iaddr_t
	typedef logic [WIDTH_INSTR-1:0]		instr_t;

endpackage

`default_nettype wire

//--- hdl/dispatch_pkg.sv
// Dispatch control and host map
`default_nettype none

package dispatch_pkg;
	import mpu_pkg::*;

	// Dispatch sequencer states
	typedef enum logic [2:0] {
		IDLE,
		GETINFO,			// Waiting on thread map
		SEND_THREADID,
		SEND_ISSUENO,
		SEND_ILENGTH,
		SEND_INSTRS			// Streaming from instruction memory
	} fsm_dispatch_t;

	// Header tag in the top two bits
	typedef enum logic [1:0] {
		THREADID	= 2'd1,
		ISSUENO		= 2'd2,
		ILENGTH		= 2'd3
	} hdr_kind_t;

	// One output word seen as instruction or header
	typedef union packed {
		instr_t			instr;
		struct packed {
			hdr_kind_t		kind;
			logic [13:0]	zero;
			logic [15:0]	value;
		} hdr;
	} dispatch_word_u;

	////////////////////
	// Host address map
	////////////////////

	localparam int WIDTH_AXI_ADDR	= 16;
	localparam int WIDTH_AXI_DATA	= 32;

	localparam logic [WIDTH_AXI_ADDR-1:0] ADDR_IMEM_BASE	= 16'h0000;		// Write only
	localparam logic [WIDTH_AXI_ADDR-1:0] ADDR_MAP_BASE		= 16'h1000;		// One word per thread
	localparam logic [WIDTH_AXI_ADDR-1:0] ADDR_ISSUE		= 16'h2000;		// Issue and status

	// Map word layout
	localparam int MAP_BASE_LSB		= 0;
	localparam int MAP_LEN_LSB		= 16;

	// AXI response codes
	localparam logic [1:0] RESP_OKAY	= 2'b00;
	localparam logic [1:0] RESP_SLVERR	= 2'b10;

endpackage

`default_nettype wire

//--- hdl/host_regs.sv
// AXI4-Lite host register block
`timescale 1ns/1ps
`default_nettype none

module host_regs
	import mpu_pkg::*;
	import dispatch_pkg::*;
(
	input	wire							clock,
	input	wire							reset,
	// AXI4-Lite write channels
	input	wire [WIDTH_AXI_ADDR-1:0]		s_awaddr,
	input	wire							s_awvalid,
	output	logic							s_awready,
	input	wire [WIDTH_AXI_DATA-1:0]		s_wdata,
	input	wire							s_wvalid,
	output	logic							s_wready,
	output	logic [1:0]						s_bresp,
	output	logic							s_bvalid,
	input	wire							s_bready,
	// AXI4-Lite read channels
	input	wire [WIDTH_AXI_ADDR-1:0]		s_araddr,
	input	wire							s_arvalid,
	output	logic							s_arready,
	output	logic [WIDTH_AXI_DATA-1:0]		s_rdata,
	output	logic [1:0]						s_rresp,
	output	logic							s_rvalid,
	input	wire							s_rready,
	// Instruction memory write
	output	logic							imem_we,
	output	iaddr_t							imem_waddr,
	output	instr_t							imem_wdata,
	// Thread map access
	output	logic							map_we,
	output	id_t							map_waddr,
	output	logic [WIDTH_AXI_DATA-1:0]		map_wdata,
	output	id_t							map_raddr,
	input	wire [WIDTH_AXI_DATA-1:0]		map_rdata,
	// Issue to dispatch
	output	logic							issue_req,
	output	id_t							issue_thread_id,
	output	issue_no_t						issue_no,
	input	wire							issue_ack,
	input	wire							busy
);

	// Region decode helpers
	function automatic logic in_imem(input logic [WIDTH_AXI_ADDR-1:0] a);
		return a[WIDTH_AXI_ADDR-1:WIDTH_IADDR+2] ==
			ADDR_IMEM_BASE[WIDTH_AXI_ADDR-1:WIDTH_IADDR+2];
	endfunction

	function automatic logic in_map(input logic [WIDTH_AXI_ADDR-1:0] a);
		return a[WIDTH_AXI_ADDR-1:WIDTH_THREAD_ID+2] ==
			ADDR_MAP_BASE[WIDTH_AXI_ADDR-1:WIDTH_THREAD_ID+2];
	endfunction

	function automatic logic is_issue(input logic [WIDTH_AXI_ADDR-1:0] a);
		return a[WIDTH_AXI_ADDR-1:2] == ADDR_ISSUE[WIDTH_AXI_ADDR-1:2];
	endfunction

	logic							aw_hs, w_hs, ar_hs;
	logic							aw_full, w_full;		// Halves of a write collected
	logic [WIDTH_AXI_ADDR-1:0]		aw_addr;
	logic [WIDTH_AXI_DATA-1:0]		w_data;
	logic							wr_do;					// Both halves present
	logic							issue_wr;				// Accepted issue write
	logic [WIDTH_AXI_DATA-1:0]		status_word;

	assign aw_hs	= s_awvalid & s_awready;
	assign w_hs		= s_wvalid & s_wready;
	assign ar_hs	= s_arvalid & s_arready;
	assign wr_do	= aw_full & w_full;

	// Refused while an issue is still waiting
	assign issue_wr	= wr_do & is_issue(aw_addr) & ~issue_req;

	////////////////////
	// Write channel
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			aw_full		<= 1'b0;
			w_full		<= 1'b0;
			s_awready	<= 1'b0;
			s_wready	<= 1'b0;
		end
		else begin
			if (aw_hs)
				aw_full	<= 1'b1;
			else if (wr_do)
				aw_full	<= 1'b0;
			if (w_hs)
				w_full	<= 1'b1;
			else if (wr_do)
				w_full	<= 1'b0;
			// Reopen only after the response has gone
			s_awready	<= ~aw_full & ~aw_hs & ~s_bvalid;
			s_wready	<= ~w_full & ~w_hs & ~s_bvalid;
		end
	end

	// Captured address and data
	always_ff @(posedge clock) begin
		if (aw_hs)
			aw_addr	<= s_awaddr;
		if (w_hs)
			w_data	<= s_wdata;
	end

	// Write response
	always_ff @(posedge clock) begin
		if (reset) begin
			s_bvalid	<= 1'b0;
			s_bresp		<= RESP_OKAY;
		end
		else if (wr_do) begin
			s_bvalid	<= 1'b1;
			s_bresp		<= (in_imem(aw_addr) | in_map(aw_addr) | issue_wr) ?
							RESP_OKAY : RESP_SLVERR;
		end
		else if (s_bready) begin
			s_bvalid	<= 1'b0;
		end
	end

	// Memory and map writes straight from the collected halves
	assign imem_we		= wr_do & in_imem(aw_addr);
	assign imem_waddr	= aw_addr[WIDTH_IADDR+1:2];
	assign imem_wdata	= w_data;
	assign map_we		= wr_do & in_map(aw_addr);
	assign map_waddr	= aw_addr[WIDTH_THREAD_ID+1:2];
	assign map_wdata	= w_data;

	////////////////////
	// Pending issue
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			issue_req	<= 1'b0;
			issue_no	<= '0;
		end
		else begin
			if (issue_wr)
				issue_req	<= 1'b1;
			else if (issue_ack)
				issue_req	<= 1'b0;
			if (issue_ack)
				issue_no	<= issue_no + 1'b1;		// Next issue number
		end
	end

	always_ff @(posedge clock) begin
		if (issue_wr)
			issue_thread_id	<= w_data[WIDTH_THREAD_ID-1:0];
	end

	////////////////////
	// Read channel
	////////////////////

	assign map_raddr	= s_araddr[WIDTH_THREAD_ID+1:2];
	assign status_word	= {16'b0, issue_no, 6'b0, busy, issue_req};

	always_ff @(posedge clock) begin
		if (reset) begin
			s_arready	<= 1'b0;
			s_rvalid	<= 1'b0;
			s_rresp		<= RESP_OKAY;
			s_rdata		<= '0;
		end
		else begin
			s_arready	<= ~ar_hs & ~s_rvalid;		// One read at a time
			if (ar_hs) begin
				s_rvalid	<= 1'b1;
				if (in_map(s_araddr)) begin
					s_rdata	<= map_rdata;
					s_rresp	<= RESP_OKAY;
				end
				else if (is_issue(s_araddr)) begin
					s_rdata	<= status_word;
					s_rresp	<= RESP_OKAY;
				end
				else begin
					s_rdata	<= '0;					// Imem reads and holes
					s_rresp	<= RESP_SLVERR;
				end
			end
			else if (s_rready) begin
				s_rvalid	<= 1'b0;
			end
		end
	end

	// Responses stay up until taken
	assert property (@(posedge clock) disable iff (reset)
		(s_bvalid && !s_bready) |=> (s_bvalid && $stable(s_bresp)))
		else $error("write response changed before bready");

	assert property (@(posedge clock) disable iff (reset)
		(s_rvalid && !s_rready) |=> (s_rvalid && $stable(s_rdata)))
		else $error("read data changed before rready");

endmodule

`default_nettype wire

//--- hdl/thread_map.sv
// Thread map table
`timescale 1ns/1ps
`default_nettype none

module thread_map
	import mpu_pkg::*;
	import dispatch_pkg::*;
(
	input	wire							clock,
	input	wire							reset,
	input	wire							map_we,
	input	id_t							map_waddr,
	input	wire [WIDTH_AXI_DATA-1:0]		map_wdata,
	input	id_t							map_raddr,
	output	logic [WIDTH_AXI_DATA-1:0]		map_rdata,
	input	wire							lookup_req,
	input	id_t							lookup_id,
	output	logic							lookup_ack,
	output	iaddr_t							lookup_base,
	output	ilen_t							lookup_len
);

	iaddr_t		base_tab [NUM_THREADS];		// Program start per thread
	ilen_t		len_tab [NUM_THREADS];		// Program length per thread
	logic		req_seen;					// Request already answered

	// Host side table write
	always_ff @(posedge clock) begin
		if (map_we) begin
			base_tab[map_waddr]	<= map_wdata[MAP_BASE_LSB +: WIDTH_IADDR];
			len_tab[map_waddr]	<= map_wdata[MAP_LEN_LSB +: WIDTH_ILEN];
		end
	end

	// Readback in the map word layout
	assign map_rdata = {{(16-WIDTH_ILEN){1'b0}}, len_tab[map_raddr],
						{(16-WIDTH_IADDR){1'b0}}, base_tab[map_raddr]};

	////////////////////
	// Lookup port
	////////////////////

	// Ack one cycle after a new request, once per request
	always_ff @(posedge clock) begin
		if (reset) begin
			lookup_ack	<= 1'b0;
			req_seen	<= 1'b0;
		end
		else begin
			lookup_ack	<= lookup_req & ~req_seen;
			req_seen	<= lookup_req;				// Cleared when request drops
		end
	end

	always_ff @(posedge clock) begin
		if (lookup_req & ~req_seen) begin
			lookup_base	<= base_tab[lookup_id];
			lookup_len	<= len_tab[lookup_id];
		end
	end

endmodule

`default_nettype wire

//--- hdl/instr_mem.sv
// Instruction memory
`timescale 1ns/1ps
`default_nettype none

module instr_mem
	import mpu_pkg::*;
(
	input	wire			clock,
	// Host write port
	input	wire			imem_we,
	input	iaddr_t			imem_waddr,
	input	instr_t			imem_wdata,
	// Dispatch read port
	input	wire			rd_en,
	input	iaddr_t			rd_addr,
	output	instr_t			rd_data
);

	instr_t		mem [IMEM_DEPTH];

	// Host loads program words
	always_ff @(posedge clock) begin
		if (imem_we)
			mem[imem_waddr]	<= imem_wdata;
	end

	// Registered read, data one cycle after rd_en
	always_ff @(posedge clock) begin
		if (rd_en)
			rd_data	<= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- hdl/dispatch_unit.sv
// Thread dispatch sequencer
`timescale 1ns/1ps
`default_nettype none

module dispatch_unit
	import mpu_pkg::*;
	import dispatch_pkg::*;
(
	input	wire				clock,
	input	wire				reset,
	// Issue from host block
	input	wire				issue_req,
	input	id_t				issue_thread_id,
	input	issue_no_t			issue_no,
	output	logic				issue_ack,
	output	logic				busy,
	// Thread map lookup
	output	logic				lookup_req,
	output	id_t				lookup_id,
	input	wire				lookup_ack,
	input	iaddr_t				lookup_base,
	input	ilen_t				lookup_len,
	// Instruction fetch
	output	logic				rd_en,
	output	iaddr_t				rd_addr,
	input	instr_t				rd_data,
	// Stream to processing units
	output	logic				tpu_valid,
	output	dispatch_word_u		tpu_word,
	output	logic				send_thread
);

	fsm_dispatch_t		state;
	id_t				thread_id_r;		// Latched on issue
	issue_no_t			issue_no_r;
	ilen_t				len_r;				// Length for the header
	ilen_t				remain;				// Reads still to go
	iaddr_t				addr_r;				// Next fetch address
	logic				loading;
	logic				last_instr;
	logic				in_header;
	dispatch_word_u		hdr_next;
	dispatch_word_u		hdr_word;
	logic				out_valid;
	logic				out_instr;			// Output slot carries memory data

	assign loading		= state == SEND_INSTRS;
	assign last_instr	= remain == ilen_t'(1);
	assign in_header	= state inside {SEND_THREADID, SEND_ISSUENO, SEND_ILENGTH};

	assign issue_ack	= (state == IDLE) & issue_req;
	assign lookup_req	= state == GETINFO;
	assign lookup_id	= thread_id_r;
	assign rd_en		= loading;
	assign rd_addr		= addr_r;
	assign busy			= state != IDLE;
	assign send_thread	= in_header | loading | out_valid;	// Covers the last registered word

	////////////////////
	// Control FSM
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state	<= IDLE;
		end
		else begin
			case (state)
				IDLE:			if (issue_req) state <= GETINFO;
				GETINFO:		if (lookup_ack) state <= SEND_THREADID;
				SEND_THREADID:	state <= SEND_ISSUENO;
				SEND_ISSUENO:	state <= SEND_ILENGTH;
				SEND_ILENGTH:	state <= SEND_INSTRS;
				SEND_INSTRS:	if (last_instr) state <= IDLE;
				default:		state <= IDLE;
			endcase
		end
	end

	// Thread ID and issue number on acceptance
	always_ff @(posedge clock) begin
		if (issue_ack) begin
			thread_id_r	<= issue_thread_id;
			issue_no_r	<= issue_no;
		end
	end

	// Base and length from the map, then count through the program
	always_ff @(posedge clock) begin
		if (reset) begin
			remain	<= '0;
		end
		else if (lookup_ack) begin
			remain	<= lookup_len;
		end
		else if (loading) begin
			remain	<= remain - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (lookup_ack) begin
			addr_r	<= lookup_base;
			len_r	<= lookup_len;
		end
		else if (loading) begin
			addr_r	<= addr_r + 1'b1;		// Consecutive words
		end
	end

	////////////////////
	// Output stage
	////////////////////

	always_comb begin
		hdr_next			= hdr_word;		// Hold between threads
		hdr_next.hdr.zero	= '0;
		case (state)
			SEND_THREADID: begin
				hdr_next.hdr.kind	= THREADID;
				hdr_next.hdr.value	= 16'(thread_id_r);
			end
			SEND_ISSUENO: begin
				hdr_next.hdr.kind	= ISSUENO;
				hdr_next.hdr.value	= 16'(issue_no_r);
			end
			SEND_ILENGTH: begin
				hdr_next.hdr.kind	= ILENGTH;
				hdr_next.hdr.value	= 16'(len_r);
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		hdr_word	<= hdr_next;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid	<= 1'b0;
			out_instr	<= 1'b0;
		end
		else begin
			out_valid	<= in_header | loading;
			out_instr	<= loading;				// Memory read lands with it
		end
	end

	// Both sources are registers one cycle after their state
	always_comb begin
		tpu_word	= hdr_word;
		if (out_instr)
			tpu_word.instr	= rd_data;
	end

	assign tpu_valid	= out_valid;

	// Map answers only while the FSM waits for it
	assert property (@(posedge clock) disable iff (reset)
		lookup_ack |-> (state == GETINFO))
		else $error("lookup_ack outside GETINFO");

	assert property (@(posedge clock) disable iff (reset)
		lookup_ack |-> (lookup_len != '0))
		else $error("zero program length from thread map");

endmodule

`default_nettype wire

//--- hdl/mpu_dispatch_top.sv
// Dispatch path top level
`timescale 1ns/1ps
`default_nettype none

module mpu_dispatch_top
	import mpu_pkg::*;
	import dispatch_pkg::*;
(
	input	wire							clock,
	input	wire							reset,
	input	wire [WIDTH_AXI_ADDR-1:0]		s_awaddr,
	input	wire							s_awvalid,
	output	logic							s_awready,
	input	wire [WIDTH_AXI_DATA-1:0]		s_wdata,
	input	wire							s_wvalid,
	output	logic							s_wready,
	output	logic [1:0]						s_bresp,
	output	logic							s_bvalid,
	input	wire							s_bready,
	input	wire [WIDTH_AXI_ADDR-1:0]		s_araddr,
	input	wire							s_arvalid,
	output	logic							s_arready,
	output	logic [WIDTH_AXI_DATA-1:0]		s_rdata,
	output	logic [1:0]						s_rresp,
	output	logic							s_rvalid,
	input	wire							s_rready,
	output	logic							tpu_valid,
	output	dispatch_word_u					tpu_word,
	output	logic							send_thread
);

	// Host to memory and map
	logic							imem_we;
	iaddr_t							imem_waddr;
	instr_t							imem_wdata;
	logic							map_we;
	id_t							map_waddr;
	logic [WIDTH_AXI_DATA-1:0]		map_wdata;
	id_t							map_raddr;
	logic [WIDTH_AXI_DATA-1:0]		map_rdata;

	// Host to dispatch
	logic							issue_req;
	id_t							issue_thread_id;
	issue_no_t						issue_no;
	logic							issue_ack;
	logic							busy;

	// Dispatch to map and memory
	logic							lookup_req;
	id_t							lookup_id;
	logic							lookup_ack;
	iaddr_t							lookup_base;
	ilen_t							lookup_len;
	logic							rd_en;
	iaddr_t							rd_addr;
	instr_t							rd_data;

	host_regs host_regs0 (
		.clock, .reset,
		.s_awaddr, .s_awvalid, .s_awready, .s_wdata, .s_wvalid, .s_wready,
		.s_bresp, .s_bvalid, .s_bready,
		.s_araddr, .s_arvalid, .s_arready, .s_rdata, .s_rresp, .s_rvalid, .s_rready,
		.imem_we, .imem_waddr, .imem_wdata,
		.map_we, .map_waddr, .map_wdata, .map_raddr, .map_rdata,
		.issue_req, .issue_thread_id, .issue_no, .issue_ack, .busy
	);

	thread_map thread_map0 (
		.clock, .reset,
		.map_we, .map_waddr, .map_wdata, .map_raddr, .map_rdata,
		.lookup_req, .lookup_id, .lookup_ack, .lookup_base, .lookup_len
	);

	instr_mem instr_mem0 (
		.clock,
		.imem_we, .imem_waddr, .imem_wdata,
		.rd_en, .rd_addr, .rd_data
	);

	dispatch_unit dispatch_unit0 (
		.clock, .reset,
		.issue_req, .issue_thread_id, .issue_no, .issue_ack, .busy,
		.lookup_req, .lookup_id, .lookup_ack, .lookup_base, .lookup_len,
		.rd_en, .rd_addr, .rd_data,
		.tpu_valid, .tpu_word, .send_thread
	);

endmodule

`default_nettype wire

//--- testbench/tb_mpu_dispatch.sv
// Dispatch path testbench
`timescale 1ns/1ps
`default_nettype none

module tb_mpu_dispatch
	import mpu_pkg::*;
	import dispatch_pkg::*;
();

	localparam int NUM_SEQ			= 6;			// Issues in the sequence test
	localparam int MAX_SEQ_LEN		= 32;
	localparam int STREAM_WORDS		= 16 + 40 + 8 + NUM_SEQ * MAX_SEQ_LEN;
	localparam int WATCH_CYCLES		= 12 * STREAM_WORDS + 2000;	// Writes plus stream, doubled
	localparam logic [15:0] LFSR_TAPS	= 16'hB400;

	logic							clock;
	logic							reset;
	logic [WIDTH_AXI_ADDR-1:0]		s_awaddr;
	logic							s_awvalid;
	logic							s_awready;
	logic [WIDTH_AXI_DATA-1:0]		s_wdata;
	logic							s_wvalid;
	logic							s_wready;
	logic [1:0]						s_bresp;
	logic							s_bvalid;
	logic							s_bready;
	logic [WIDTH_AXI_ADDR-1:0]		s_araddr;
	logic							s_arvalid;
	logic							s_arready;
	logic [WIDTH_AXI_DATA-1:0]		s_rdata;
	logic [1:0]						s_rresp;
	logic							s_rvalid;
	logic							s_rready;
	logic							tpu_valid;
	dispatch_word_u					tpu_word;
	logic							send_thread;

	logic [31:0]		model_mem [IMEM_DEPTH];		// What the host wrote
	logic [31:0]		word_q [$];					// Collected stream words
	int unsigned		stamp_q [$];				// Cycle of each word
	int unsigned		cycle_no = 0;
	logic [15:0]		lfsr_state = 16'd16;
	int					next_issue = 0;				// Expected issue number
	int					check_count = 0;
	int					error_count = 0;
	int					tests_run = 0;

	mpu_dispatch_top dut0 (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock) cycle_no <= cycle_no + 1;

	////////////////////
	// Helpers
	////////////////////

	// Galois LFSR, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ LFSR_TAPS : lfsr_state >> 1;
		end
		return v;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		logic aw_done;
		logic w_done;
		logic aw_now;
		logic w_now;
		aw_done = 1'b0;
		w_done = 1'b0;
		@(posedge clock);
		s_awaddr	<= addr;
		s_awvalid	<= 1'b1;
		s_wdata		<= data;
		s_wvalid	<= 1'b1;
		while (!(aw_done && w_done)) begin
			@(negedge clock);
			aw_now = s_awvalid & s_awready;		// Handshake on the coming edge
			w_now = s_wvalid & s_wready;
			@(posedge clock);
			if (aw_now) begin
				s_awvalid	<= 1'b0;
				aw_done = 1'b1;
			end
			if (w_now) begin
				s_wvalid	<= 1'b0;
				w_done = 1'b1;
			end
		end
		@(negedge clock);
		while (!s_bvalid) @(negedge clock);
		resp = s_bresp;
		@(posedge clock);
		s_bready	<= 1'b1;			// Response waits a cycle before it is taken
		@(posedge clock);
		s_bready	<= 1'b0;
	endtask

	task automatic axi_read(input logic [15:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		@(posedge clock);
		s_araddr	<= addr;
		s_arvalid	<= 1'b1;
		@(negedge clock);
		while (!s_arready) @(negedge clock);
		@(posedge clock);
		s_arvalid	<= 1'b0;
		@(negedge clock);
		while (!s_rvalid) @(negedge clock);
		data = s_rdata;
		resp = s_rresp;
		@(posedge clock);
		s_rready	<= 1'b1;			// Data waits a cycle before it is taken
		@(posedge clock);
		s_rready	<= 1'b0;
	endtask

	// Map entry plus random program words
	task automatic program_thread(input int id, input int base, input int len);
		logic [1:0] resp;
		logic [31:0] word;
		axi_write(ADDR_MAP_BASE + 16'(id * 4), {16'(len), 16'(base)}, resp);
		check_value("map s_bresp", 32'(resp), 32'(RESP_OKAY));
		for (int k = 0; k < len; k++) begin
			word = take_bits(32);
			model_mem[base + k] = word;
			axi_write(ADDR_IMEM_BASE + 16'((base + k) * 4), word, resp);
			check_value("imem s_bresp", 32'(resp), 32'(RESP_OKAY));
		end
	endtask

	task automatic start_issue(input int id, input logic [1:0] exp_resp);
		logic [1:0] resp;
		axi_write(ADDR_ISSUE, 32'(id), resp);
		check_value("issue s_bresp", 32'(resp), 32'(exp_resp));
	endtask

	// Three headers then the program, one word per cycle
	task automatic expect_stream(input int id, input int issue, input int base, input int len);
		int n;
		int unsigned t0;
		logic [31:0] exp;
		n = 3 + len;
		while (word_q.size() < n) @(negedge clock);
		t0 = stamp_q[0];
		for (int i = 0; i < n; i++) begin
			if (i == 0)
				exp = {THREADID, 14'b0, 16'(id)};
			else if (i == 1)
				exp = {ISSUENO, 14'b0, 8'b0, 8'(issue)};
			else if (i == 2)
				exp = {ILENGTH, 14'b0, 16'(len)};
			else
				exp = model_mem[base + i - 3];
			check_value("tpu_word", word_q.pop_front(), exp);
			check_value("tpu_valid cycle", stamp_q.pop_front() - t0, 32'(i));	// No gaps
		end
	endtask

	// Poll status until nothing is pending or running
	task automatic wait_idle();
		logic [31:0] st;
		logic [1:0] resp;
		axi_read(ADDR_ISSUE, st, resp);
		while (st[1:0] != 2'b00) axi_read(ADDR_ISSUE, st, resp);
		check_value("words left over", 32'(word_q.size()), 32'd0);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		$display("%-16s %s", name, (error_count == errs_before) ? "ok" : "mismatch");
	endtask

	// Stream monitor
	always @(negedge clock) begin
		if (!reset && tpu_valid) begin
			word_q.push_back(tpu_word);
			stamp_q.push_back(cycle_no);
			check_value("send_thread", 32'(send_thread), 32'd1);
		end
	end

	////////////////////
	// Tests
	////////////////////

	task automatic reset_state();
		int e0;
		logic [31:0] st;
		logic [1:0] resp;
		e0 = error_count;
		@(negedge clock);
		check_value("tpu_valid", 32'(tpu_valid), 32'd0);
		check_value("send_thread", 32'(send_thread), 32'd0);
		axi_read(ADDR_ISSUE, st, resp);
		check_value("status", st, 32'd0);
		check_value("status s_rresp", 32'(resp), 32'(RESP_OKAY));
		finish_test("reset_state", e0);
	endtask

	task automatic single_issue();
		int e0;
		e0 = error_count;
		program_thread(5, 100, 16);
		start_issue(5, RESP_OKAY);
		expect_stream(5, next_issue, 100, 16);		// First issue number is 0
		next_issue++;
		wait_idle();
		finish_test("single_issue", e0);
	endtask

	task automatic map_readback();
		int e0;
		int id;
		logic [31:0] entry;
		logic [31:0] rd;
		logic [1:0] resp;
		e0 = error_count;
		repeat (4) begin
			id = take_bits(6);
			entry = {16'(take_bits(10) + 1), 16'(take_bits(10))};
			axi_write(ADDR_MAP_BASE + 16'(id * 4), entry, resp);
			check_value("map s_bresp", 32'(resp), 32'(RESP_OKAY));
			axi_read(ADDR_MAP_BASE + 16'(id * 4), rd, resp);
			check_value("map readback", rd, entry);
			check_value("map s_rresp", 32'(resp), 32'(RESP_OKAY));
		end
		axi_read(ADDR_IMEM_BASE + 16'h0010, rd, resp);		// Imem is write only
		check_value("imem s_rresp", 32'(resp), 32'(RESP_SLVERR));
		axi_read(16'h3000, rd, resp);
		check_value("hole s_rresp", 32'(resp), 32'(RESP_SLVERR));
		axi_write(16'h3004, 32'h1234_5678, resp);
		check_value("hole s_bresp", 32'(resp), 32'(RESP_SLVERR));
		finish_test("map_readback", e0);
	endtask

	task automatic refused_issue();
		int e0;
		logic [31:0] st;
		logic [1:0] resp;
		e0 = error_count;
		program_thread(10, 200, 40);
		program_thread(11, 300, 8);
		start_issue(10, RESP_OKAY);			// Runs at once
		start_issue(11, RESP_OKAY);			// Waits behind thread 10
		axi_read(ADDR_ISSUE, st, resp);
		check_value("status", st, {16'b0, 8'(next_issue + 1), 6'b0, 1'b1, 1'b1});
		start_issue(12, RESP_SLVERR);
		expect_stream(10, next_issue, 200, 40);
		expect_stream(11, next_issue + 1, 300, 8);
		next_issue += 2;
		wait_idle();						// Nothing from thread 12
		finish_test("refused_issue", e0);
	endtask

	task automatic issue_sequence();
		int e0;
		int id;
		int len;
		int base;
		e0 = error_count;
		repeat (NUM_SEQ) begin
			id = take_bits(6);
			len = take_bits(5) + 1;
			base = take_bits(9);			// Stays clear of the top
			program_thread(id, base, len);
			start_issue(id, RESP_OKAY);
			expect_stream(id, next_issue, base, len);
			next_issue++;
			wait_idle();
		end
		finish_test("issue_sequence", e0);
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		reset = 1'b1;
		s_awaddr = '0;
		s_awvalid = 1'b0;
		s_wdata = '0;
		s_wvalid = 1'b0;
		s_bready = 1'b0;
		s_araddr = '0;
		s_arvalid = 1'b0;
		s_rready = 1'b0;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		reset_state();
		single_issue();
		map_readback();
		refused_issue();
		issue_sequence();
		$display("tests %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
		if (error_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCH_CYCLES) @(posedge clock);
		$display("watchdog: run did not finish within %0d cycles", WATCH_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
hdl/mpu_pkg.sv
hdl/dispatch_pkg.sv
hdl/host_regs.sv
hdl/thread_map.sv
hdl/instr_mem.sv
hdl/dispatch_unit.sv
hdl/mpu_dispatch_top.sv
testbench/tb_mpu_dispatch.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_mpu_dispatch \
	-f files.f -o tb_mpu_dispatch > build.log 2>&1 &&
./obj_dir/tb_mpu_dispatch > sim.log 2>&1 ||
echo "build or simulation stopped with an error, see build.log and sim.log"
grep -q "TESTBENCH PASSED" sim.log 2>/dev/null && echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
